// File: include/icache_defines.svh
//*********************************************************************
// Size macros for the front-end instruction cache.
// Include this header wherever a cache dimension or field width is
// needed. The types built from these sizes live in the packages.
//*********************************************************************
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// geometry
`define ICACHE_SETS           64
`define ICACHE_WAYS           4
`define ICACHE_LINE_WORDS     4

// widths
`define ICACHE_WORD_W         32
`define ICACHE_VADDR_W        32
`define ICACHE_PADDR_W        32
`define ICACHE_PAGE_OFFSET_W  12
`define ICACHE_INDEX_W        6
`define ICACHE_OFFSET_W       2

// physical address bits above the page offset
`define ICACHE_TAG_W          20

`endif

// File: logic/icache_pkg.sv
//*********************************************************************
// Lookup-path types of the instruction cache: addresses, set index,
// word offset, way number, tag entries and pseudo-LRU tree bits.
// Import into any module on the lookup path.
//*********************************************************************
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  // byte offset inside one instruction word
  localparam int unsigned BYTE_OFF_W = $clog2(`ICACHE_WORD_W / 8);
  // lowest address bit of the set index
  localparam int unsigned INDEX_LSB = BYTE_OFF_W + `ICACHE_OFFSET_W;

  typedef logic [`ICACHE_VADDR_W-1:0] vaddr_t;
  typedef logic [`ICACHE_PADDR_W-1:0] paddr_t;

  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_OFFSET_W-1:0] word_off_t;
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;
  typedef logic [`ICACHE_TAG_W-1:0] ptag_t;

  typedef struct packed {
    logic  valid;
    ptag_t ptag;
  } tag_entry_t;

  // bit 0 is the root, bits 1 and 2 the leaves of half 0 and half 1
  typedef logic [`ICACHE_WAYS-2:0] lru_bits_t;

endpackage

`default_nettype wire

// File: logic/icache_fill_pkg.sv
//*********************************************************************
// Types exchanged between the instruction cache and its refill agent:
// the miss request sent out and the tag and data packets of a fill.
// Import into modules that drive or decode these packets.
//*********************************************************************
`default_nettype none

`include "icache_defines.svh"

package icache_fill_pkg;

  import icache_pkg::*;

  // line address has zero word and byte offset
  typedef struct packed {
    paddr_t line_addr;
    way_t   way;
  } miss_req_t;

  typedef enum logic [1:0] {
    TAG_CLEAR_SET  = 2'd0,
    TAG_SET        = 2'd1,
    TAG_INVALIDATE = 2'd2
  } tag_op_e;

  typedef struct packed {
    tag_op_e op;
    index_t  index;
    way_t    way;
    ptag_t   ptag;
  } tag_pkt_t;

  // word offset of a beat comes from the fill counter
  typedef struct packed {
    index_t                    index;
    way_t                      way;
    logic [`ICACHE_WORD_W-1:0] word;
  } data_pkt_t;

endpackage

`default_nettype wire

// File: logic/icache_tag_store.sv
//*********************************************************************
// Tag memory of the instruction cache. Applies tag packets, reads all
// ways of a set one cycle after the address, and in the following
// cycle compares them with the registered physical tag. Also reports
// the lowest invalid way of that set for replacement.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_tag_store
  import icache_pkg::*;
  import icache_fill_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     reset_i,
  input  wire logic     rd_en_i,
  input  wire index_t   rd_index_i,
  input  wire tag_pkt_t tag_pkt_i,
  input  wire logic     tag_wr_i,
  input  wire ptag_t    ptag_i,
  output logic          hit_o,
  output way_t          hit_way_o,
  output logic          invalid_exist_o,
  output way_t          invalid_way_o
);

  tag_entry_t tag_mem [`ICACHE_SETS][`ICACHE_WAYS];

  tag_entry_t [`ICACHE_WAYS-1:0] entries_rd_q;
  tag_entry_t [`ICACHE_WAYS-1:0] entries_tv_q;
  ptag_t                         ptag_tv_q;

  // memory is held off while reset is asserted
  always_ff @(posedge clk_i) begin
    if (tag_wr_i && !reset_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        case (tag_pkt_i.op)
          TAG_CLEAR_SET: tag_mem[tag_pkt_i.index][w] <= '0;
          TAG_SET: begin
            if (tag_pkt_i.way == way_t'(w)) begin
              tag_mem[tag_pkt_i.index][w] <= '{valid: 1'b1, ptag: tag_pkt_i.ptag};
            end
          end
          TAG_INVALIDATE: begin
            if (tag_pkt_i.way == way_t'(w)) begin
              tag_mem[tag_pkt_i.index][w].valid <= 1'b0;
            end
          end
          default: ;
        endcase
      end
    end
    if (rd_en_i && !reset_i) begin
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        entries_rd_q[w] <= tag_mem[rd_index_i][w];
      end
    end
  end

  // second stage, lines up with the tag that arrives a cycle late
  always_ff @(posedge clk_i) begin
    entries_tv_q <= entries_rd_q;
    ptag_tv_q    <= ptag_i;
  end

  // downward scan so the lowest way wins
  always_comb begin
    hit_o           = 1'b0;
    hit_way_o       = '0;
    invalid_exist_o = 1'b0;
    invalid_way_o   = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (entries_tv_q[w].valid && (entries_tv_q[w].ptag == ptag_tv_q)) begin
        hit_o     = 1'b1;
        hit_way_o = way_t'(w);
      end
      if (!entries_tv_q[w].valid) begin
        invalid_exist_o = 1'b1;
        invalid_way_o   = way_t'(w);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/icache_data_store.sv
//*********************************************************************
// Data memory of the instruction cache, one word array per way.
// Fill beats write a single way; a lookup reads the addressed word of
// every way and the hit way picks the returned instruction two cycles
// after the address.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_data_store
  import icache_pkg::*;
  import icache_fill_pkg::*;
(
  input  wire logic                      clk_i,
  input  wire logic                      rd_en_i,
  input  wire index_t                    rd_index_i,
  input  wire word_off_t                 rd_off_i,
  input  wire way_t                      hit_way_i,
  input  wire data_pkt_t                 data_pkt_i,
  input  wire logic                      beat_wr_i,
  input  wire word_off_t                 beat_off_i,
  output logic [`ICACHE_WORD_W-1:0]      instr_o
);

  localparam int unsigned DEPTH = `ICACHE_SETS * `ICACHE_LINE_WORDS;

  logic [`ICACHE_WORD_W-1:0] words_rd_q [`ICACHE_WAYS];
  logic [`ICACHE_WORD_W-1:0] words_tv_q [`ICACHE_WAYS];

  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    logic [`ICACHE_WORD_W-1:0] mem [DEPTH];

    always_ff @(posedge clk_i) begin
      if (beat_wr_i && (data_pkt_i.way == way_t'(w))) begin
        mem[{data_pkt_i.index, beat_off_i}] <= data_pkt_i.word;
      end
      if (rd_en_i) begin
        words_rd_q[w] <= mem[{rd_index_i, rd_off_i}];
      end
      // held for the compare cycle
      words_tv_q[w] <= words_rd_q[w];
    end
  end

  assign instr_o = words_tv_q[hit_way_i];

endmodule

`default_nettype wire

// File: logic/icache_lru_store.sv
//*********************************************************************
// Tree pseudo-LRU state of the instruction cache, three bits per set.
// Read combinationally for the set in the compare stage and updated
// at the clock edge on a hit. Gives the replacement way, preferring
// an invalid way over the LRU way.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_lru_store
  import icache_pkg::*;
(
  input  wire logic   clk_i,
  input  wire logic   reset_i,
  input  wire index_t index_i,
  input  wire logic   hit_i,
  input  wire way_t   hit_way_i,
  input  wire logic   invalid_exist_i,
  input  wire way_t   invalid_way_i,
  output way_t        repl_way_o
);

  lru_bits_t lru_q [`ICACHE_SETS];
  lru_bits_t lru_rd;
  logic      lru_half;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        lru_q[s] <= '0;
      end
    end else if (hit_i) begin
      // root toward the other half
      lru_q[index_i][0] <= ~hit_way_i[1];
      // leaf toward the other way of the hit half
      lru_q[index_i][1 + hit_way_i[1]] <= ~hit_way_i[0];
    end
  end

  assign lru_rd   = lru_q[index_i];
  assign lru_half = lru_rd[0];

  always_comb begin
    if (invalid_exist_i) begin
      repl_way_o = invalid_way_i;
    end else begin
      repl_way_o = {lru_half, lru_rd[1 + lru_half]};
    end
  end

endmodule

`default_nettype wire

// File: logic/icache_fill_counter.sv
//*********************************************************************
// Beat counter for line fills. Counts accepted data beats modulo the
// line length, supplies the word offset of the current beat and
// pulses line_done_o with the last beat of a line.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_fill_counter
  import icache_pkg::*;
(
  input  wire logic clk_i,
  input  wire logic reset_i,
  input  wire logic beat_i,
  output word_off_t beat_off_o,
  output logic      line_done_o
);

  word_off_t count_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (beat_i) begin
      // wraps to zero after the last word
      count_q <= count_q + 1'b1;
    end
  end

  assign beat_off_o  = count_q;
  assign line_done_o = beat_i && (count_q == word_off_t'(`ICACHE_LINE_WORDS - 1));

endmodule

`default_nettype wire

// File: logic/icache_miss_fsm.sv
//*********************************************************************
// Miss handler of the instruction cache. On a miss it captures the
// request, holds it valid until the refill agent takes it, then waits
// for the line fill to complete. busy_o stalls new lookups from the
// miss cycle until the fill is done.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

module icache_miss_fsm
  import icache_pkg::*;
  import icache_fill_pkg::*;
(
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire logic      miss_i,
  input  wire miss_req_t req_i,
  input  wire logic      miss_req_ready_i,
  input  wire logic      line_done_i,
  output miss_req_t      miss_req_o,
  output logic           miss_req_v_o,
  output logic           busy_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_FILL
  } state_e;

  state_e    state_q;
  miss_req_t req_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (miss_i) state_q <= ST_REQ;
        ST_REQ:  if (miss_req_ready_i) state_q <= ST_FILL;
        ST_FILL: if (line_done_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // request stays stable while waiting for ready
  always_ff @(posedge clk_i) begin
    if ((state_q == ST_IDLE) && miss_i) begin
      req_q <= req_i;
    end
  end

  assign miss_req_o   = req_q;
  assign miss_req_v_o = (state_q == ST_REQ);
  assign busy_o       = (state_q != ST_IDLE) || miss_i;

endmodule

`default_nettype wire

// File: logic/fe_icache.sv
//*********************************************************************
// Front-end instruction cache, 4-way, virtually indexed and physically
// tagged. A lookup is accepted in TL, takes its physical tag one cycle
// later and resolves in TV as a hit or a miss. Misses issue a line
// request and stall lookups until the tag packet and all data beats
// of the line have been written.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module fe_icache
  import icache_pkg::*;
  import icache_fill_pkg::*;
(
  input  wire logic                 clk_i,
  input  wire logic                 reset_i,

  input  wire vaddr_t               vaddr_i,
  input  wire logic                 vaddr_v_i,
  output logic                      vaddr_ready_o,

  input  wire ptag_t                ptag_i,
  input  wire logic                 ptag_v_i,

  output logic [`ICACHE_WORD_W-1:0] instr_o,
  output logic                      instr_v_o,
  output logic                      miss_o,

  output miss_req_t                 miss_req_o,
  output logic                      miss_req_v_o,
  input  wire logic                 miss_req_ready_i,

  input  wire tag_pkt_t             tag_pkt_i,
  input  wire logic                 tag_pkt_v_i,
  output logic                      tag_pkt_ready_o,

  input  wire data_pkt_t            data_pkt_i,
  input  wire logic                 data_pkt_v_i,
  output logic                      data_pkt_ready_o
);

  logic      accept;
  logic      busy;
  logic      tl_v_q;
  vaddr_t    tl_vaddr_q;
  logic      tv_we;
  logic      tv_v_q;
  paddr_t    tv_paddr_q;
  index_t    tv_index;
  logic      hit;
  way_t      hit_way;
  logic      invalid_exist;
  way_t      invalid_way;
  way_t      repl_way;
  logic      tv_miss;
  miss_req_t req;
  logic      tag_wr;
  logic      beat_wr;
  word_off_t beat_off;
  logic      line_done;

  assign vaddr_ready_o = ~busy;
  assign accept        = vaddr_v_i & vaddr_ready_o;

  // single-ported memories, lookups win over fill packets
  assign tag_pkt_ready_o  = ~accept;
  assign data_pkt_ready_o = ~accept;
  assign tag_wr           = tag_pkt_v_i & tag_pkt_ready_o;
  assign beat_wr          = data_pkt_v_i & data_pkt_ready_o;

  // TL stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tl_v_q <= 1'b0;
    end else begin
      tl_v_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      tl_vaddr_q <= vaddr_i;
    end
  end

  // a miss in TV flushes the item behind it
  assign tv_we = tl_v_q & ptag_v_i & ~tv_miss;

  // TV stage
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tv_v_q <= 1'b0;
    end else begin
      tv_v_q <= tv_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tv_we) begin
      tv_paddr_q <= {ptag_i, tl_vaddr_q[`ICACHE_PAGE_OFFSET_W-1:0]};
    end
  end

  assign tv_index  = tv_paddr_q[INDEX_LSB +: `ICACHE_INDEX_W];
  assign tv_miss   = tv_v_q & ~hit;
  assign miss_o    = tv_miss;
  assign instr_v_o = tv_v_q & hit;

  assign req.line_addr = {tv_paddr_q[`ICACHE_PADDR_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
  assign req.way       = repl_way;

  icache_tag_store i_tag_store (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .rd_en_i         (accept),
    .rd_index_i      (vaddr_i[INDEX_LSB +: `ICACHE_INDEX_W]),
    .tag_pkt_i       (tag_pkt_i),
    .tag_wr_i        (tag_wr),
    .ptag_i          (ptag_i),
    .hit_o           (hit),
    .hit_way_o       (hit_way),
    .invalid_exist_o (invalid_exist),
    .invalid_way_o   (invalid_way)
  );

  icache_data_store i_data_store (
    .clk_i      (clk_i),
    .rd_en_i    (accept),
    .rd_index_i (vaddr_i[INDEX_LSB +: `ICACHE_INDEX_W]),
    .rd_off_i   (vaddr_i[BYTE_OFF_W +: `ICACHE_OFFSET_W]),
    .hit_way_i  (hit_way),
    .data_pkt_i (data_pkt_i),
    .beat_wr_i  (beat_wr),
    .beat_off_i (beat_off),
    .instr_o    (instr_o)
  );

  icache_lru_store i_lru_store (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .index_i         (tv_index),
    .hit_i           (instr_v_o),
    .hit_way_i       (hit_way),
    .invalid_exist_i (invalid_exist),
    .invalid_way_i   (invalid_way),
    .repl_way_o      (repl_way)
  );

  icache_fill_counter i_fill_counter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .beat_i      (beat_wr),
    .beat_off_o  (beat_off),
    .line_done_o (line_done)
  );

  icache_miss_fsm i_miss_fsm (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .miss_i           (tv_miss),
    .req_i            (req),
    .miss_req_ready_i (miss_req_ready_i),
    .line_done_i      (line_done),
    .miss_req_o       (miss_req_o),
    .miss_req_v_o     (miss_req_v_o),
    .busy_o           (busy)
  );

endmodule

`default_nettype wire

// File: verification/fe_icache_tb.sv
//*********************************************************************
// Trace-driven testbench for the front-end instruction cache.
// Steps are read from the trace file in the verification folder. A
// reference model of valid bits, tags and tree PLRU bits predicts
// the replacement way of every miss. Run from the project root.
//*********************************************************************
`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module fe_icache_tb
  import icache_pkg::*;
  import icache_fill_pkg::*;
();

  localparam int TRACE_WORDS    = 320;
  localparam int FIELDS         = 5;
  localparam int TIMEOUT_CYCLES = 200;

  localparam int SIG_VADDR_READY = 0;
  localparam int SIG_REQ_VALID   = 1;
  localparam int SIG_TAG_READY   = 2;
  localparam int SIG_DATA_READY  = 3;

  logic                      clk_i;
  logic                      reset_i;
  vaddr_t                    vaddr_i;
  logic                      vaddr_v_i;
  logic                      vaddr_ready_o;
  ptag_t                     ptag_i;
  logic                      ptag_v_i;
  logic [`ICACHE_WORD_W-1:0] instr_o;
  logic                      instr_v_o;
  logic                      miss_o;
  miss_req_t                 miss_req_o;
  logic                      miss_req_v_o;
  logic                      miss_req_ready_i;
  tag_pkt_t                  tag_pkt_i;
  logic                      tag_pkt_v_i;
  logic                      tag_pkt_ready_o;
  data_pkt_t                 data_pkt_i;
  logic                      data_pkt_v_i;
  logic                      data_pkt_ready_o;

  logic [31:0] trace_mem [TRACE_WORDS];

  // reference model of the cache state
  logic  model_valid [`ICACHE_SETS][`ICACHE_WAYS];
  ptag_t model_tag   [`ICACHE_SETS][`ICACHE_WAYS];
  logic  model_root  [`ICACHE_SETS];
  logic  model_leaf  [`ICACHE_SETS][2];

  // line whose fill words come next in the trace
  logic   fill_pending;
  index_t fill_index;
  way_t   fill_way;
  ptag_t  fill_ptag;

  fe_icache i_fe_icache (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("ERROR time %0t: %s = %b, expected %b",
                              $time, name, actual, expected));
    end
  endtask

  task automatic check_instr(input logic [`ICACHE_WORD_W-1:0] actual,
                             input logic [`ICACHE_WORD_W-1:0] expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("ERROR time %0t: instr_o = %h, expected %h",
                              $time, actual, expected));
    end
  endtask

  task automatic check_req(input miss_req_t actual, input miss_req_t expected);
    if (actual !== expected) begin
      stop_on_error($sformatf(
        "ERROR time %0t: miss_req_o = line %h way %0d, expected line %h way %0d",
        $time, actual.line_addr, actual.way, expected.line_addr, expected.way));
    end
  endtask

  function automatic logic watched(input int sel);
    case (sel)
      SIG_VADDR_READY: watched = vaddr_ready_o;
      SIG_REQ_VALID:   watched = miss_req_v_o;
      SIG_TAG_READY:   watched = tag_pkt_ready_o;
      default:         watched = data_pkt_ready_o;
    endcase
  endfunction

  // polls at the falling edge, where outputs have settled
  task automatic wait_until(input int sel, input string name);
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!watched(sel)) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_on_error($sformatf("timeout: %s stayed low for %0d cycles", name, cycles));
      end
      @(negedge clk_i);
    end
  endtask

  function automatic index_t index_of(input vaddr_t va);
    return va[INDEX_LSB +: `ICACHE_INDEX_W];
  endfunction

  // invalid way first, then follow the tree bits
  function automatic way_t model_victim(input index_t idx);
    logic half;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (!model_valid[idx][w]) begin
        return way_t'(w);
      end
    end
    half = model_root[idx];
    return {half, model_leaf[idx][half]};
  endfunction

  task automatic model_hit(input index_t idx, input ptag_t pt);
    int   found;
    way_t way;
    found = -1;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (model_valid[idx][w] && (model_tag[idx][w] == pt)) begin
        found = w;
      end
    end
    if (found < 0) begin
      stop_on_error("trace expects a hit on a line the reference model does not hold");
    end
    way = way_t'(found);
    // point both levels of the tree away from the hit way
    model_root[idx]         = ~way[1];
    model_leaf[idx][way[1]] = ~way[0];
  endtask

  task automatic send_tag(input tag_op_e op, input index_t idx, input way_t way,
                          input ptag_t pt);
    tag_pkt_t pkt;
    pkt.op    = op;
    pkt.index = idx;
    pkt.way   = way;
    pkt.ptag  = pt;
    @(posedge clk_i);
    tag_pkt_i   <= pkt;
    tag_pkt_v_i <= 1'b1;
    wait_until(SIG_TAG_READY, "tag_pkt_ready_o");
    @(posedge clk_i);
    tag_pkt_v_i <= 1'b0;
  endtask

  task automatic send_beat(input data_pkt_t beat);
    @(posedge clk_i);
    data_pkt_i   <= beat;
    data_pkt_v_i <= 1'b1;
    wait_until(SIG_DATA_READY, "data_pkt_ready_o");
    // lookups stay stalled until the last beat is in
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
    @(posedge clk_i);
    data_pkt_v_i <= 1'b0;
  endtask

  // one lookup, returns at the falling edge of the result cycle
  task automatic issue_lookup(input vaddr_t va, input ptag_t pt, input logic pt_v);
    wait_until(SIG_VADDR_READY, "vaddr_ready_o");
    @(posedge clk_i);
    vaddr_i   <= va;
    vaddr_v_i <= 1'b1;
    // fill ports yield to the accepted lookup
    @(negedge clk_i);
    check_flag("tag_pkt_ready_o", tag_pkt_ready_o, 1'b0);
    check_flag("data_pkt_ready_o", data_pkt_ready_o, 1'b0);
    @(posedge clk_i);
    vaddr_v_i <= 1'b0;
    ptag_i    <= pt;
    ptag_v_i  <= pt_v;
    @(posedge clk_i);
    ptag_v_i  <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic run_clear();
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      send_tag(TAG_CLEAR_SET, index_t'(s), '0, '0);
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
      end
    end
  endtask

  task automatic run_hit(input vaddr_t va, input ptag_t pt,
                         input logic [`ICACHE_WORD_W-1:0] word);
    issue_lookup(va, pt, 1'b1);
    check_flag("instr_v_o", instr_v_o, 1'b1);
    check_flag("miss_o", miss_o, 1'b0);
    check_instr(instr_o, word);
    model_hit(index_of(va), pt);
  endtask

  // two lookups in consecutive cycles to neighbouring words
  task automatic run_pair(input vaddr_t va, input ptag_t pt,
                          input logic [`ICACHE_WORD_W-1:0] word0,
                          input logic [`ICACHE_WORD_W-1:0] word1);
    wait_until(SIG_VADDR_READY, "vaddr_ready_o");
    @(posedge clk_i);
    vaddr_i   <= va;
    vaddr_v_i <= 1'b1;
    @(posedge clk_i);
    vaddr_i   <= va + vaddr_t'(4);
    ptag_i    <= pt;
    ptag_v_i  <= 1'b1;
    @(posedge clk_i);
    vaddr_v_i <= 1'b0;
    @(negedge clk_i);
    check_flag("instr_v_o", instr_v_o, 1'b1);
    check_instr(instr_o, word0);
    @(posedge clk_i);
    ptag_v_i  <= 1'b0;
    @(negedge clk_i);
    check_flag("instr_v_o", instr_v_o, 1'b1);
    check_instr(instr_o, word1);
    model_hit(index_of(va), pt);
    model_hit(index_of(va), pt);
  endtask

  task automatic run_miss(input vaddr_t va, input ptag_t pt);
    miss_req_t expected;
    expected.line_addr = {pt, va[`ICACHE_PAGE_OFFSET_W-1:INDEX_LSB], {INDEX_LSB{1'b0}}};
    expected.way       = model_victim(index_of(va));
    issue_lookup(va, pt, 1'b1);
    check_flag("miss_o", miss_o, 1'b1);
    check_flag("instr_v_o", instr_v_o, 1'b0);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b0);
    wait_until(SIG_REQ_VALID, "miss_req_v_o");
    check_req(miss_req_o, expected);
    // hold ready low one more cycle, the request must stay put
    @(negedge clk_i);
    check_flag("miss_req_v_o", miss_req_v_o, 1'b1);
    check_req(miss_req_o, expected);
    @(posedge clk_i);
    miss_req_ready_i <= 1'b1;
    @(posedge clk_i);
    miss_req_ready_i <= 1'b0;
    fill_pending = 1'b1;
    fill_index   = index_of(va);
    fill_way     = expected.way;
    fill_ptag    = pt;
    send_tag(TAG_SET, fill_index, fill_way, fill_ptag);
  endtask

  task automatic run_fill(input int base);
    data_pkt_t beat;
    if (!fill_pending) begin
      stop_on_error("trace holds fill words without a miss before them");
    end
    for (int k = 0; k < `ICACHE_LINE_WORDS; k++) begin
      beat.index = fill_index;
      beat.way   = fill_way;
      beat.word  = trace_mem[base + 1 + k];
      send_beat(beat);
    end
    wait_until(SIG_VADDR_READY, "vaddr_ready_o after the line fill");
    model_valid[fill_index][fill_way] = 1'b1;
    model_tag[fill_index][fill_way]   = fill_ptag;
    fill_pending = 1'b0;
  endtask

  task automatic run_dropped(input vaddr_t va, input ptag_t pt);
    issue_lookup(va, pt, 1'b0);
    check_flag("instr_v_o", instr_v_o, 1'b0);
    check_flag("miss_o", miss_o, 1'b0);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
  endtask

  initial begin
    int   step;
    int   base;
    logic done;
    reset_i          <= 1'b1;
    vaddr_i          <= '0;
    vaddr_v_i        <= 1'b0;
    ptag_i           <= '0;
    ptag_v_i         <= 1'b0;
    miss_req_ready_i <= 1'b0;
    tag_pkt_i        <= '0;
    tag_pkt_v_i      <= 1'b0;
    data_pkt_i       <= '0;
    data_pkt_v_i     <= 1'b0;
    for (int s = 0; s < `ICACHE_SETS; s++) begin
      model_root[s]    = 1'b0;
      model_leaf[s][0] = 1'b0;
      model_leaf[s][1] = 1'b0;
      for (int w = 0; w < `ICACHE_WAYS; w++) begin
        model_valid[s][w] = 1'b0;
      end
    end
    fill_pending = 1'b0;
    $readmemh("verification/fe_icache_trace.txt", trace_mem);
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // idle outputs straight after reset
    @(negedge clk_i);
    check_flag("vaddr_ready_o", vaddr_ready_o, 1'b1);
    check_flag("instr_v_o", instr_v_o, 1'b0);
    check_flag("miss_o", miss_o, 1'b0);
    check_flag("miss_req_v_o", miss_req_v_o, 1'b0);

    step = 0;
    done = 1'b0;
    while (!done) begin
      base = step * FIELDS;
      if (base + FIELDS > TRACE_WORDS) begin
        stop_on_error("trace ran past its last step without an end step");
      end
      case (trace_mem[base])
        0: done = 1'b1;
        1: run_clear();
        2: run_hit(trace_mem[base + 1], ptag_t'(trace_mem[base + 2]), trace_mem[base + 3]);
        3: run_miss(trace_mem[base + 1], ptag_t'(trace_mem[base + 2]));
        4: run_fill(base);
        5: run_pair(trace_mem[base + 1], ptag_t'(trace_mem[base + 2]),
                    trace_mem[base + 3], trace_mem[base + 4]);
        6: begin
          send_tag(TAG_INVALIDATE, index_t'(trace_mem[base + 1]),
                   way_t'(trace_mem[base + 2]), '0);
          model_valid[index_t'(trace_mem[base + 1])][way_t'(trace_mem[base + 2])] = 1'b0;
        end
        7: run_dropped(trace_mem[base + 1], ptag_t'(trace_mem[base + 2]));
        default: stop_on_error($sformatf("unknown trace op %0h at step %0d",
                                         trace_mem[base], step));
      endcase
      step++;
    end

    repeat (2) @(posedge clk_i);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/fe_icache_trace.txt
// hex columns: op a b c d; op 1 clear all sets, 2 hit (a vaddr, b ptag, c word)
// 3 miss (a vaddr, b ptag), 4 fill words 0..3 in a..d, 5 back-to-back hits (c word, d next)
// 6 invalidate (a index, b way), 7 lookup without ptag (a vaddr, b ptag), 0 end
1 0 0 0 0
// first line of set 5 goes to way 0
3 00000058 12345 0 0
4 aa000000 aa000001 aa000002 aa000003
2 00000058 12345 aa000002 0
5 00000050 12345 aa000000 aa000001
5 00000058 12345 aa000002 aa000003
// fill the other three ways of set 5
3 00000054 23456 0 0
4 bb000000 bb000001 bb000002 bb000003
3 0000005c 34567 0 0
4 cc000000 cc000001 cc000002 cc000003
3 00000050 45678 0 0
4 dd000000 dd000001 dd000002 dd000003
// hits on ways 1, 3 and 0 leave way 2 as the PLRU victim
2 00000054 23456 bb000001 0
2 0000005c 45678 dd000003 0
2 00000050 12345 aa000000 0
3 00000054 56789 0 0
4 ee000000 ee000001 ee000002 ee000003
2 00000054 56789 ee000001 0
// invalidated way is refilled first
6 5 1 0 0
3 00000058 23456 0 0
4 bb000000 bb000001 bb000002 bb000003
2 00000058 23456 bb000002 0
// lookup dropped for lack of a physical tag
7 00000050 12345 0 0
2 0000005c 12345 aa000003 0
// another set, upper virtual bits differ from the physical page
3 7fff1a34 0abcd 0 0
4 5a5a0000 5a5a0001 5a5a0002 5a5a0003
2 7fff1a3c 0abcd 5a5a0003 0
0 0 0 0 0

// File: fe_icache.f
+incdir+include
logic/icache_pkg.sv
logic/icache_fill_pkg.sv
logic/icache_tag_store.sv
logic/icache_data_store.sv
logic/icache_lru_store.sv
logic/icache_fill_counter.sv
logic/icache_miss_fsm.sv
logic/fe_icache.sv
verification/fe_icache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the instruction cache testbench with Verilator and runs it.
# Exits non-zero when the build or the simulation fails.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module fe_icache_tb \
  -f fe_icache.f \
  --Mdir obj_dir \
  -o fe_icache_sim

./obj_dir/fe_icache_sim
